//--- source/sdram_mux_pkg.sv
package sdram_mux_pkg;

	// ========================================================================
	// Widths
	// ========================================================================

	// SDRAM byte address, bit 0 stays low in word mode
	localparam int sdram_addr_w = 25;
	// 68k word address, bits 23:1
	localparam int m68k_addr_w = 23;
	// Four-word burst returned by the SDRAM
	localparam int burst_w = 64;
	localparam int word_w = 16;

	// ========================================================================
	// SDRAM map
	// ========================================================================

	localparam logic [sdram_addr_w-1:0] region_sysrom = 25'h0000000;
	localparam logic [sdram_addr_w-1:0] region_srom   = 25'h0080000;
	localparam logic [sdram_addr_w-1:0] region_sfix   = 25'h0100000;
	localparam logic [sdram_addr_w-1:0] region_p1     = 25'h0200000;
	// P2 on cartridges, extended RAM on CD systems
	localparam logic [sdram_addr_w-1:0] region_p2     = 25'h0300000;
	localparam logic [sdram_addr_w-1:0] region_crom   = 25'h0800000;

	// System type as chosen at reset
	typedef enum logic [1:0] {console, arcade, cd, cdz} system_t;

	// Access currently owning the SDRAM port
	typedef enum logic [2:0] {acc_none, acc_cd_wr, acc_crom, acc_srom, acc_m68k} access_t;

	// Decoded 68k read zone
	typedef enum logic [1:0] {zone_none, zone_rom, zone_port, zone_sysrom} m68k_zone_t;

	// Request levels, pck1 and pck2 are active low as on the board
	typedef struct packed {
		logic m68k_sel;
		logic pck1;
		logic pck2;
		logic cd_wr_sel;
	} req_in_t;

	typedef struct packed {
		logic rd;
		logic we;
		logic [sdram_addr_w-1:0] addr;
		logic [word_w-1:0] din;
	} sdram_cmd_t;

	typedef struct packed {
		logic ready_first;
		logic ready_fourth;
		logic [burst_w-1:0] dout;
	} sdram_rsp_t;

	// Video side latches and timing strobes
	typedef struct packed {
		logic [23:0] c_latch;
		logic [word_w-1:0] s_latch;
		logic ca4;
		logic s2h1;
		logic load;
	} gfx_bus_t;

endpackage

//--- source/sdram_arbiter.sv
`timescale 1ns/1ps

module sdram_arbiter
(
	input  logic clk_sys,
	input  logic nBNKB,
	input  sdram_mux_pkg::req_in_t requests,
	input  sdram_mux_pkg::system_t system,
	input  logic ready_first,
	input  logic ready_fourth,
	output sdram_mux_pkg::access_t cur_access,
	output logic rd,
	output logic we,
	output logic ready_first_rise,
	output logic ready_fourth_rise
);

	// ========================================================================
	// Edge detection
	// ========================================================================

	// Two-stage history per request level
	logic [1:0] m68k_sr;
	logic [1:0] crom_sr;
	logic [1:0] srom_sr;
	logic [1:0] cd_sr;
	logic [1:0] rf_sr;
	logic [1:0] r4_sr;

	logic m68k_edge;
	logic crom_edge;
	logic srom_edge;
	logic cd_edge;
	logic is_cd;

	// Pending and running flags
	logic m68k_req;
	logic crom_req;
	logic srom_req;
	logic cd_req;
	logic m68k_run;
	logic crom_run;
	logic srom_run;
	logic cd_run;

	// Pending flag or fresh edge, merged
	logic want_m68k;
	logic want_crom;
	logic want_srom;
	logic want_cd;
	logic port_free;
	sdram_mux_pkg::access_t grant;

	assign is_cd = (system == sdram_mux_pkg::cd) || (system == sdram_mux_pkg::cdz);

	assign m68k_edge = (m68k_sr == 2'b01);
	assign crom_edge = (crom_sr == 2'b01);
	assign srom_edge = (srom_sr == 2'b01);
	// CD transfers only exist on CD systems
	assign cd_edge = (cd_sr == 2'b01) & is_cd;

	assign ready_first_rise = (rf_sr == 2'b01);
	assign ready_fourth_rise = (r4_sr == 2'b01);

	assign want_m68k = m68k_req | m68k_edge;
	assign want_crom = crom_req | crom_edge;
	assign want_srom = srom_req | srom_edge;
	assign want_cd = cd_req | cd_edge;

	// ========================================================================
	// Priority choice
	// ========================================================================

	// Free once both ready levels have passed through the edge history
	// A late ready edge of one access then never ends the next one
	assign port_free = rf_sr[0] & r4_sr[0] & ~rd & ~we &
		~(m68k_run | crom_run | srom_run | cd_run);

	// CD write, then C ROM, then S ROM, then 68k
	always_comb
	begin
		grant = sdram_mux_pkg::acc_none;
		if (port_free)
		begin
			if (want_cd)
				grant = sdram_mux_pkg::acc_cd_wr;
			else if (want_crom)
				grant = sdram_mux_pkg::acc_crom;
			else if (want_srom)
				grant = sdram_mux_pkg::acc_srom;
			else if (want_m68k)
				grant = sdram_mux_pkg::acc_m68k;
		end
	end

	// Owner of the port follows the running flag
	always_comb
	begin
		if (cd_run)
			cur_access = sdram_mux_pkg::acc_cd_wr;
		else if (crom_run)
			cur_access = sdram_mux_pkg::acc_crom;
		else if (srom_run)
			cur_access = sdram_mux_pkg::acc_srom;
		else if (m68k_run)
			cur_access = sdram_mux_pkg::acc_m68k;
		else
			cur_access = sdram_mux_pkg::acc_none;
	end

	// ========================================================================
	// Flags and command pulses
	// ========================================================================

	always_ff @(posedge clk_sys or negedge nBNKB)
	begin
		if (!nBNKB)
		begin
			m68k_sr <= 2'b00;
			crom_sr <= 2'b00;
			srom_sr <= 2'b00;
			cd_sr <= 2'b00;
			rf_sr <= 2'b00;
			r4_sr <= 2'b00;
			m68k_req <= 1'b0;
			crom_req <= 1'b0;
			srom_req <= 1'b0;
			cd_req <= 1'b0;
			m68k_run <= 1'b0;
			crom_run <= 1'b0;
			srom_run <= 1'b0;
			cd_run <= 1'b0;
			rd <= 1'b0;
			we <= 1'b0;
		end
		else
		begin
			m68k_sr <= {m68k_sr[0], requests.m68k_sel};
			// Graphics strobes are active low
			crom_sr <= {crom_sr[0], ~requests.pck1};
			srom_sr <= {srom_sr[0], ~requests.pck2};
			cd_sr <= {cd_sr[0], requests.cd_wr_sel};
			rf_sr <= {rf_sr[0], ready_first};
			r4_sr <= {r4_sr[0], ready_fourth};

			// Anything not granted this cycle waits
			m68k_req <= want_m68k & (grant != sdram_mux_pkg::acc_m68k);
			crom_req <= want_crom & (grant != sdram_mux_pkg::acc_crom);
			srom_req <= want_srom & (grant != sdram_mux_pkg::acc_srom);
			cd_req <= want_cd & (grant != sdram_mux_pkg::acc_cd_wr);

			// Bursts end on the fourth word, the rest on the first
			m68k_run <= (m68k_run & ~ready_first_rise) | (grant == sdram_mux_pkg::acc_m68k);
			srom_run <= (srom_run & ~ready_first_rise) | (grant == sdram_mux_pkg::acc_srom);
			cd_run <= (cd_run & ~ready_first_rise) | (grant == sdram_mux_pkg::acc_cd_wr);
			crom_run <= (crom_run & ~ready_fourth_rise) | (grant == sdram_mux_pkg::acc_crom);

			// Single cycle pulses
			rd <= (grant == sdram_mux_pkg::acc_crom) || (grant == sdram_mux_pkg::acc_srom) ||
				(grant == sdram_mux_pkg::acc_m68k);
			we <= (grant == sdram_mux_pkg::acc_cd_wr);
		end
	end

endmodule

//--- source/sdram_addr_map.sv
`timescale 1ns/1ps

module sdram_addr_map
(
	input  logic clk_sys,
	input  logic nBNKB,
	input  sdram_mux_pkg::access_t cur_access,
	input  sdram_mux_pkg::gfx_bus_t gfx,
	input  logic [sdram_mux_pkg::m68k_addr_w:1] m68k_addr,
	input  sdram_mux_pkg::m68k_zone_t m68k_zone,
	input  logic [sdram_mux_pkg::word_w-1:0] m68k_wdata,
	input  logic [2:0] cd_area,
	input  logic [1:0] cd_bank_spr,
	input  logic port_wr,
	input  sdram_mux_pkg::system_t system,
	input  logic nsystem,
	output logic [sdram_mux_pkg::sdram_addr_w-1:0] cmd_addr
);

	logic is_cd;
	// P2 bank, 1 MB window
	logic [1:0] p_bank;
	logic [sdram_mux_pkg::sdram_addr_w-1:0] cd_addr_next;
	logic [sdram_mux_pkg::sdram_addr_w-1:0] cd_addr_q;
	logic [sdram_mux_pkg::sdram_addr_w-1:0] srom_base;

	assign is_cd = (system == sdram_mux_pkg::cd) || (system == sdram_mux_pkg::cdz);

	// Bank stays at 0 on CD systems
	always_ff @(posedge clk_sys or negedge nBNKB)
	begin
		if (!nBNKB)
			p_bank <= 2'd0;
		else if (port_wr && !is_cd)
			p_bank <= m68k_wdata[1:0];
	end

	// ========================================================================
	// CD transfer address
	// ========================================================================

	always_comb
	begin
		case (cd_area)
			// EXT zone
			3'd7: cd_addr_next = sdram_mux_pkg::region_p1 + {4'b0, m68k_addr[20:1], 1'b0};
			// Sprites, word order swapped inside the 64-byte tile line
			3'd0: cd_addr_next = sdram_mux_pkg::region_crom +
				{3'b0, cd_bank_spr, m68k_addr[19:6], ~m68k_addr[1], m68k_addr[5:2], 1'b0};
			// Fix
			3'd5: cd_addr_next = sdram_mux_pkg::region_srom +
				{8'b0, m68k_addr[16:5], ~m68k_addr[1], 1'b0, m68k_addr[4:3], 1'b0};
			default: cd_addr_next = '0;
		endcase
	end

	// Tracks the inputs until the write starts, then holds
	always_ff @(posedge clk_sys)
	begin
		if (cur_access != sdram_mux_pkg::acc_cd_wr)
			cd_addr_q <= cd_addr_next;
	end

	// ========================================================================
	// Address select
	// ========================================================================

	// SFIX only when the system ROM asks for it on a cartridge system
	assign srom_base = (!nsystem && !is_cd) ? sdram_mux_pkg::region_sfix :
		sdram_mux_pkg::region_srom;

	always_comb
	begin
		cmd_addr = '0;
		case (cur_access)
			sdram_mux_pkg::acc_cd_wr: cmd_addr = cd_addr_q;
			sdram_mux_pkg::acc_crom: cmd_addr = {gfx.c_latch, 1'b0} + sdram_mux_pkg::region_crom;
			// Bit 3 inverted puts the two fix columns in burst order
			sdram_mux_pkg::acc_srom: cmd_addr = srom_base +
				{8'b0, gfx.s_latch[15:4], gfx.s_latch[2:0], ~gfx.s_latch[3], 1'b0};
			sdram_mux_pkg::acc_m68k:
			begin
				case (m68k_zone)
					sdram_mux_pkg::zone_rom:
						cmd_addr = sdram_mux_pkg::region_p1 + {5'b0, m68k_addr[19:1], 1'b0};
					sdram_mux_pkg::zone_port:
						cmd_addr = sdram_mux_pkg::region_p2 + {3'b0, p_bank, 20'h00000} +
							{5'b0, m68k_addr[19:1], 1'b0};
					// 512 kB on CD, 128 kB on cartridge
					sdram_mux_pkg::zone_sysrom:
						cmd_addr = is_cd ?
							sdram_mux_pkg::region_sysrom + {6'b0, m68k_addr[18:1], 1'b0} :
							sdram_mux_pkg::region_sysrom + {8'b0, m68k_addr[16:1], 1'b0};
					default: cmd_addr = '0;
				endcase
			end
			default: cmd_addr = '0;
		endcase
	end

endmodule

//--- source/sdram_read_capture.sv
`timescale 1ns/1ps

module sdram_read_capture
(
	input  logic clk_sys,
	input  logic nBNKB,
	input  sdram_mux_pkg::access_t cur_access,
	input  logic ready_first_rise,
	input  logic ready_fourth_rise,
	input  logic [sdram_mux_pkg::burst_w-1:0] dout,
	input  sdram_mux_pkg::gfx_bus_t gfx,
	output logic [sdram_mux_pkg::word_w-1:0] prom_data,
	output logic prom_valid,
	output logic [31:0] sprite_data,
	output logic spr_valid,
	output logic [7:0] fix_pixels,
	output logic fix_valid
);

	logic m68k_done;
	logic srom_done;
	logic crom_done;
	logic [sdram_mux_pkg::word_w-1:0] srom_q;
	logic [sdram_mux_pkg::burst_w-1:0] crom_q;
	logic [1:0] load_sr;
	logic ca4_q;

	assign m68k_done = ready_first_rise && (cur_access == sdram_mux_pkg::acc_m68k);
	assign srom_done = ready_first_rise && (cur_access == sdram_mux_pkg::acc_srom);
	assign crom_done = ready_fourth_rise && (cur_access == sdram_mux_pkg::acc_crom);

	// ========================================================================
	// Holding registers
	// ========================================================================

	// First word of the burst sits in the top bits
	always_ff @(posedge clk_sys)
	begin
		if (m68k_done)
			prom_data <= dout[63:48];
		if (srom_done)
			srom_q <= dout[63:48];
		if (crom_done)
			crom_q <= dout;
	end

	// Valid pulses and CA4 tracking
	always_ff @(posedge clk_sys or negedge nBNKB)
	begin
		if (!nBNKB)
		begin
			prom_valid <= 1'b0;
			fix_valid <= 1'b0;
			spr_valid <= 1'b0;
			load_sr <= 2'b00;
			ca4_q <= 1'b0;
		end
		else
		begin
			prom_valid <= m68k_done;
			fix_valid <= srom_done;
			spr_valid <= crom_done;
			load_sr <= {load_sr[0], gfx.load};
			// CA4 polarity follows h-flip so it is taken at load time
			if (load_sr == 2'b01)
				ca4_q <= gfx.ca4;
		end
	end

	// Half of the C ROM burst for the current 8 pixels
	assign sprite_data = ca4_q ? crom_q[63:32] : crom_q[31:0];

	// One read serves both fix columns
	assign fix_pixels = gfx.s2h1 ? srom_q[15:8] : srom_q[7:0];

endmodule

//--- source/neogeo_sdram_mux.sv
`timescale 1ns/1ps

module neogeo_sdram_mux
(
	input  logic clk_sys,
	input  logic nBNKB,
	input  sdram_mux_pkg::req_in_t requests,
	input  sdram_mux_pkg::gfx_bus_t gfx,
	input  logic [sdram_mux_pkg::m68k_addr_w:1] m68k_addr,
	input  sdram_mux_pkg::m68k_zone_t m68k_zone,
	input  logic [sdram_mux_pkg::word_w-1:0] m68k_wdata,
	input  logic [2:0] cd_area,
	input  logic [1:0] cd_bank_spr,
	input  logic port_wr,
	input  sdram_mux_pkg::system_t system,
	input  logic nsystem,
	input  sdram_mux_pkg::sdram_rsp_t sdram_rsp,
	output sdram_mux_pkg::sdram_cmd_t sdram_cmd,
	output logic [sdram_mux_pkg::word_w-1:0] prom_data,
	output logic prom_valid,
	output logic [31:0] sprite_data,
	output logic spr_valid,
	output logic [7:0] fix_pixels,
	output logic fix_valid
);

	sdram_mux_pkg::access_t cur_access;
	logic rd;
	logic we;
	logic ready_first_rise;
	logic ready_fourth_rise;
	logic [sdram_mux_pkg::sdram_addr_w-1:0] cmd_addr;

	// ========================================================================
	// Port control
	// ========================================================================

	sdram_arbiter u_arbiter
	(
		.clk_sys(clk_sys),
		.nBNKB(nBNKB),
		.requests(requests),
		.system(system),
		.ready_first(sdram_rsp.ready_first),
		.ready_fourth(sdram_rsp.ready_fourth),
		.cur_access(cur_access),
		.rd(rd),
		.we(we),
		.ready_first_rise(ready_first_rise),
		.ready_fourth_rise(ready_fourth_rise)
	);

	sdram_addr_map u_addr_map
	(
		.clk_sys(clk_sys),
		.nBNKB(nBNKB),
		.cur_access(cur_access),
		.gfx(gfx),
		.m68k_addr(m68k_addr),
		.m68k_zone(m68k_zone),
		.m68k_wdata(m68k_wdata),
		.cd_area(cd_area),
		.cd_bank_spr(cd_bank_spr),
		.port_wr(port_wr),
		.system(system),
		.nsystem(nsystem),
		.cmd_addr(cmd_addr)
	);

	sdram_read_capture u_capture
	(
		.clk_sys(clk_sys),
		.nBNKB(nBNKB),
		.cur_access(cur_access),
		.ready_first_rise(ready_first_rise),
		.ready_fourth_rise(ready_fourth_rise),
		.dout(sdram_rsp.dout),
		.gfx(gfx),
		.prom_data(prom_data),
		.prom_valid(prom_valid),
		.sprite_data(sprite_data),
		.spr_valid(spr_valid),
		.fix_pixels(fix_pixels),
		.fix_valid(fix_valid)
	);

	// Command bundle, write data only during CD transfers
	always_comb
	begin
		sdram_cmd.rd = rd;
		sdram_cmd.we = we;
		sdram_cmd.addr = cmd_addr;
		sdram_cmd.din = (cur_access == sdram_mux_pkg::acc_cd_wr) ? m68k_wdata : '0;
	end

endmodule

//--- tb/sdram_model.sv
`timescale 1ns/1ps

module sdram_model
(
	input  logic clk_sys,
	input  logic nBNKB,
	input  sdram_mux_pkg::sdram_cmd_t cmd,
	output sdram_mux_pkg::sdram_rsp_t rsp
);

	// Written words, everything else reads back as the address pattern
	logic [15:0] mem [logic [24:0]];
	logic [24:0] addr_q;
	int cnt;
	logic busy;

	// Write log read by the testbench
	int wr_count;
	logic [24:0] last_waddr;
	logic [15:0] last_wdata;

	// Word k of a burst, pattern is base address xor k times 0x1111
	function automatic logic [15:0] word_at(input logic [24:0] base, input int k);
		logic [24:0] a;
		a = base + 25'(2 * k);
		if (mem.exists(a))
			return mem[a];
		return base[15:0] ^ 16'(k * 16'h1111);
	endfunction

	always @(posedge clk_sys or negedge nBNKB)
	begin
		if (!nBNKB)
		begin
			rsp <= '0;
			rsp.ready_first <= 1'b1;
			rsp.ready_fourth <= 1'b1;
			busy <= 1'b0;
			cnt <= 0;
			wr_count = 0;
		end
		else if (cmd.rd || cmd.we)
		begin
			rsp.ready_first <= 1'b0;
			rsp.ready_fourth <= 1'b0;
			busy <= 1'b1;
			cnt <= 0;
			addr_q <= cmd.addr;
			if (cmd.we)
			begin
				mem[cmd.addr] = cmd.din;
				last_waddr = cmd.addr;
				last_wdata = cmd.din;
				wr_count = wr_count + 1;
			end
		end
		else if (busy)
		begin
			cnt <= cnt + 1;
			// Fixed latency, first word then the rest of the burst
			if (cnt == 5)
			begin
				rsp.ready_first <= 1'b1;
				rsp.dout <= {word_at(addr_q, 0), word_at(addr_q, 1),
					word_at(addr_q, 2), word_at(addr_q, 3)};
			end
			if (cnt == 8)
			begin
				rsp.ready_fourth <= 1'b1;
				busy <= 1'b0;
			end
		end
	end

endmodule

//--- tb/sdram_mux_checker.sv
`timescale 1ns/1ps

module sdram_mux_checker
(
	input logic clk_sys,
	input logic nBNKB,
	input logic rd,
	input logic we,
	input logic ready_first
);

	int fail_count = 0;

	// Read and write never share a cycle
	assert property (@(posedge clk_sys) disable iff (!nBNKB) !(rd && we))
	else
	begin
		fail_count++;
		$error("rd and we high in the same cycle");
	end

	// Pulses last one cycle
	assert property (@(posedge clk_sys) disable iff (!nBNKB) rd |=> !rd)
	else
	begin
		fail_count++;
		$error("rd pulse longer than one cycle");
	end

	assert property (@(posedge clk_sys) disable iff (!nBNKB) we |=> !we)
	else
	begin
		fail_count++;
		$error("we pulse longer than one cycle");
	end

	// SDRAM must be ready when a command goes out
	assert property (@(posedge clk_sys) disable iff (!nBNKB) (rd || we) |-> ready_first)
	else
	begin
		fail_count++;
		$error("command pulse while ready_first low");
	end

endmodule

bind sdram_arbiter sdram_mux_checker u_checker
(
	.clk_sys(clk_sys),
	.nBNKB(nBNKB),
	.rd(rd),
	.we(we),
	.ready_first(ready_first)
);

//--- tb/tb_neogeo_sdram_mux.sv
`timescale 1ns/1ps

module tb_neogeo_sdram_mux;

	localparam int n_entries = 16;

	// Kind 0 68k read, 1 C ROM, 2 S ROM, 3 CD write
	typedef struct packed {
		logic [1:0] kind;
		sdram_mux_pkg::system_t sys;
		sdram_mux_pkg::m68k_zone_t zone;
		logic [1:0] bank;
		logic nsys;
		logic ca4;
		logic s2h1;
		logic [2:0] area;
		logic exact;
		logic [23:1] addr;
		logic [23:0] clatch;
		logic [15:0] slatch;
		logic [15:0] wdata;
		logic [24:0] exp_addr;
		logic [31:0] exp_data;
	} entry_t;

	logic clk_sys;
	logic nBNKB;
	sdram_mux_pkg::req_in_t requests;
	sdram_mux_pkg::gfx_bus_t gfx;
	logic [23:1] m68k_addr;
	sdram_mux_pkg::m68k_zone_t m68k_zone;
	logic [15:0] m68k_wdata;
	logic [2:0] cd_area;
	logic [1:0] cd_bank_spr;
	logic port_wr;
	sdram_mux_pkg::system_t system;
	logic nsystem;
	sdram_mux_pkg::sdram_rsp_t sdram_rsp;
	sdram_mux_pkg::sdram_cmd_t sdram_cmd;
	logic [15:0] prom_data;
	logic prom_valid;
	logic [31:0] sprite_data;
	logic spr_valid;
	logic [7:0] fix_pixels;
	logic fix_valid;

	entry_t table_q [n_entries];
	int n_added;
	logic [31:0] rng;
	int errors;
	int checks;
	// Words the CD writes leave in the EXT zone
	logic [15:0] ext_mem [logic [24:0]];
	int order_q [$];

	neogeo_sdram_mux uut
	(
		.clk_sys(clk_sys),
		.nBNKB(nBNKB),
		.requests(requests),
		.gfx(gfx),
		.m68k_addr(m68k_addr),
		.m68k_zone(m68k_zone),
		.m68k_wdata(m68k_wdata),
		.cd_area(cd_area),
		.cd_bank_spr(cd_bank_spr),
		.port_wr(port_wr),
		.system(system),
		.nsystem(nsystem),
		.sdram_rsp(sdram_rsp),
		.sdram_cmd(sdram_cmd),
		.prom_data(prom_data),
		.prom_valid(prom_valid),
		.sprite_data(sprite_data),
		.spr_valid(spr_valid),
		.fix_pixels(fix_pixels),
		.fix_valid(fix_valid)
	);

	sdram_model u_model
	(
		.clk_sys(clk_sys),
		.nBNKB(nBNKB),
		.cmd(sdram_cmd),
		.rsp(sdram_rsp)
	);

	always #20 clk_sys = ~clk_sys;

	// Completion order, 1 sprite, 2 fix, 0 program
	always @(negedge clk_sys)
	begin
		if (spr_valid)
			order_q.push_back(1);
		if (fix_valid)
			order_q.push_back(2);
		if (prom_valid)
			order_q.push_back(0);
	end

	// ========================================================================
	// Reference rules
	// ========================================================================

	function automatic logic [31:0] xorshift();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	function automatic logic [15:0] pat(input logic [24:0] a, input int k);
		return a[15:0] ^ 16'(k * 16'h1111);
	endfunction

	function automatic logic is_cd_sys(input sdram_mux_pkg::system_t s);
		return (s == sdram_mux_pkg::cd) || (s == sdram_mux_pkg::cdz);
	endfunction

	// Half of the C ROM burst picked by the latched CA4
	function automatic logic [31:0] sprite_expect(input logic [23:0] c, input logic ca4);
		logic [24:0] a;
		a = 25'h800000 + {c, 1'b0};
		return ca4 ? {pat(a, 0), pat(a, 1)} : {pat(a, 2), pat(a, 3)};
	endfunction

	// Fix byte from the srom or sfix region
	function automatic logic [7:0] fix_expect(input logic [15:0] s,
		input sdram_mux_pkg::system_t sys, input logic nsys, input logic s2h1);
		logic [24:0] a;
		logic [15:0] w;
		a = (!nsys && !is_cd_sys(sys)) ? 25'h100000 : 25'h080000;
		a = a + {s[15:4], s[2:0], ~s[3], 1'b0};
		w = pat(a, 0);
		return s2h1 ? w[15:8] : w[7:0];
	endfunction

	task automatic add_entry(input logic [1:0] kind, input sdram_mux_pkg::system_t sys,
		input sdram_mux_pkg::m68k_zone_t zone, input logic [1:0] bank, input logic nsys,
		input logic ca4, input logic s2h1, input logic [2:0] area, input logic [23:1] addr);
		entry_t e;
		logic [24:0] a;
		e = '0;
		e.kind = kind;
		e.sys = sys;
		e.zone = zone;
		e.bank = bank;
		e.nsys = nsys;
		e.ca4 = ca4;
		e.s2h1 = s2h1;
		e.area = area;
		e.addr = addr;
		e.exact = 1'b1;
		e.clatch = {2'b00, xorshift() & 32'h3fffff};
		e.slatch = xorshift();
		e.wdata = xorshift();
		case (kind)
			2'd0:
			begin
				if (zone == sdram_mux_pkg::zone_rom)
					a = 25'h200000 + {addr[19:1], 1'b0};
				else if (zone == sdram_mux_pkg::zone_port)
					a = 25'h300000 + 25'(bank) * 25'h100000 + {addr[19:1], 1'b0};
				else if (is_cd_sys(sys))
					a = {addr[18:1], 1'b0};
				else
					a = {addr[16:1], 1'b0};
				e.exp_addr = a;
				e.exp_data = ext_mem.exists(a) ? ext_mem[a] : pat(a, 0);
			end
			2'd1:
				e.exp_data = sprite_expect(e.clatch, ca4);
			2'd2:
				e.exp_data = fix_expect(e.slatch, sys, nsys, s2h1);
			default:
			begin
				// Sprite and fix writes only checked to land in their region
				case (area)
					3'd7: a = 25'h200000 + {addr[20:1], 1'b0};
					3'd0: a = 25'h800000;
					3'd5: a = 25'h080000;
					default: a = 25'h0;
				endcase
				e.exact = (area != 3'd0) && (area != 3'd5);
				e.exp_addr = a;
				if (area == 3'd7 && is_cd_sys(sys))
					ext_mem[a] = e.wdata;
			end
		endcase
		table_q[n_added] = e;
		n_added++;
	endtask

	task automatic report_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("ERR %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// ========================================================================
	// Entry sequencing
	// ========================================================================

	task automatic run_entry(input entry_t e);
		int wc0;
		int n;
		logic got;
		@(posedge clk_sys);
		system <= e.sys;
		nsystem <= e.nsys;
		m68k_zone <= e.zone;
		m68k_addr <= e.addr;
		cd_area <= e.area;
		gfx.c_latch <= e.clatch;
		gfx.s_latch <= e.slatch;
		gfx.ca4 <= e.ca4;
		gfx.s2h1 <= e.s2h1;
		gfx.load <= 1'b1;
		m68k_wdata <= (e.zone == sdram_mux_pkg::zone_port) ? 16'(e.bank) : e.wdata;
		port_wr <= (e.kind == 2'd0) && (e.zone == sdram_mux_pkg::zone_port);
		@(posedge clk_sys);
		gfx.load <= 1'b0;
		port_wr <= 1'b0;
		m68k_wdata <= e.wdata;
		@(posedge clk_sys);
		wc0 = u_model.wr_count;
		case (e.kind)
			2'd0: requests.m68k_sel <= 1'b1;
			2'd1: requests.pck1 <= 1'b0;
			2'd2: requests.pck2 <= 1'b0;
			default: requests.cd_wr_sel <= 1'b1;
		endcase
		got = 1'b0;
		for (n = 0; n < 40 && !got; n++)
		begin
			@(negedge clk_sys);
			case (e.kind)
				2'd0: got = prom_valid;
				2'd1: got = spr_valid;
				2'd2: got = fix_valid;
				default: got = (u_model.wr_count != wc0);
			endcase
		end
		checks++;
		if (e.kind == 2'd3 && !is_cd_sys(e.sys))
		begin
			if (got)
			begin
				errors++;
				$display("A CD write was issued on a cartridge system at %0t", $time);
			end
		end
		else if (!got)
		begin
			errors++;
			$display("Access of kind %0d never completed at %0t", e.kind, $time);
		end
		else if (e.kind == 2'd0)
			report_value("prom_data", prom_data, e.exp_data);
		else if (e.kind == 2'd1)
			report_value("sprite_data", sprite_data, e.exp_data);
		else if (e.kind == 2'd2)
			report_value("fix_pixels", fix_pixels, e.exp_data);
		else
		begin
			report_value("sdram_din", u_model.last_wdata, e.wdata);
			if (e.exact)
				report_value("sdram_waddr", u_model.last_waddr, e.exp_addr);
			else if (u_model.last_waddr < e.exp_addr ||
				u_model.last_waddr >= e.exp_addr + 25'h100000)
			begin
				errors++;
				$display("CD write at %h fell outside its region at %0t",
					u_model.last_waddr, $time);
			end
		end
		@(posedge clk_sys);
		requests <= 4'b0110;
		repeat (8) @(posedge clk_sys);
	endtask

	initial
	begin
		int i;
		entry_t last;
		clk_sys = 1'b0;
		nBNKB = 1'b0;
		requests = 4'b0110;
		gfx = '0;
		m68k_addr = '0;
		m68k_zone = sdram_mux_pkg::zone_none;
		m68k_wdata = '0;
		cd_area = '0;
		cd_bank_spr = '0;
		port_wr = 1'b0;
		system = sdram_mux_pkg::console;
		nsystem = 1'b1;
		rng = 32'd45828;
		errors = 0;
		checks = 0;
		n_added = 0;

		add_entry(0, sdram_mux_pkg::console, sdram_mux_pkg::zone_rom, 0, 1, 0, 0, 0,
			xorshift() & 32'h6fffff);
		add_entry(0, sdram_mux_pkg::console, sdram_mux_pkg::zone_port, 2, 1, 0, 0, 0,
			xorshift() & 32'h6fffff);
		add_entry(0, sdram_mux_pkg::arcade, sdram_mux_pkg::zone_sysrom, 0, 1, 0, 0, 0,
			xorshift() & 32'h6fffff);
		add_entry(0, sdram_mux_pkg::cd, sdram_mux_pkg::zone_rom, 0, 1, 0, 0, 0,
			xorshift() & 32'h6fffff);
		add_entry(0, sdram_mux_pkg::cdz, sdram_mux_pkg::zone_sysrom, 0, 1, 0, 0, 0,
			xorshift() & 32'h6fffff);
		add_entry(1, sdram_mux_pkg::arcade, sdram_mux_pkg::zone_none, 0, 1, 1, 0, 0, 0);
		add_entry(1, sdram_mux_pkg::console, sdram_mux_pkg::zone_none, 0, 1, 0, 0, 0, 0);
		add_entry(2, sdram_mux_pkg::console, sdram_mux_pkg::zone_none, 0, 1, 0, 1, 0, 0);
		add_entry(2, sdram_mux_pkg::console, sdram_mux_pkg::zone_none, 0, 0, 0, 0, 0, 0);
		add_entry(2, sdram_mux_pkg::cd, sdram_mux_pkg::zone_none, 0, 0, 0, 1, 0, 0);
		add_entry(3, sdram_mux_pkg::cd, sdram_mux_pkg::zone_none, 0, 1, 0, 0, 7,
			23'h05a5a5);
		add_entry(3, sdram_mux_pkg::cd, sdram_mux_pkg::zone_none, 0, 1, 0, 0, 0,
			xorshift() & 32'h6fffff);
		add_entry(3, sdram_mux_pkg::cdz, sdram_mux_pkg::zone_none, 0, 1, 0, 0, 5,
			xorshift() & 32'h6fffff);
		add_entry(3, sdram_mux_pkg::cdz, sdram_mux_pkg::zone_none, 0, 1, 0, 0, 3,
			xorshift() & 32'h6fffff);
		add_entry(3, sdram_mux_pkg::console, sdram_mux_pkg::zone_none, 0, 1, 0, 0, 7,
			23'h011110);
		// Reads back the EXT word of the first CD write
		add_entry(0, sdram_mux_pkg::cd, sdram_mux_pkg::zone_rom, 0, 1, 0, 0, 0,
			23'h05a5a5);

		repeat (3) @(posedge clk_sys);
		nBNKB <= 1'b1;
		// Quiet port until a request rises
		repeat (6)
		begin
			@(negedge clk_sys);
			checks++;
			if (sdram_cmd.rd || sdram_cmd.we || prom_valid || spr_valid || fix_valid)
			begin
				errors++;
				$display("Port active after reset without any request at %0t", $time);
			end
		end

		for (i = 0; i < n_entries; i++)
			run_entry(table_q[i]);

		// Three requests arrive while a CD write holds the port
		@(posedge clk_sys);
		system <= sdram_mux_pkg::cd;
		cd_area <= 3'd3;
		m68k_zone <= sdram_mux_pkg::zone_rom;
		requests.cd_wr_sel <= 1'b1;
		repeat (4) @(posedge clk_sys);
		order_q.delete();
		requests <= 4'b1001;
		for (i = 0; i < 200 && order_q.size() < 3; i++)
			@(negedge clk_sys);
		repeat (40) @(negedge clk_sys);
		checks++;
		if (order_q.size() != 3 || order_q[0] != 1 || order_q[1] != 2 || order_q[2] != 0)
		begin
			errors++;
			$display("Concurrent requests completed wrong, %0d completions", order_q.size());
		end

		// Address and video inputs still hold the last entry's values
		last = table_q[n_entries - 1];
		report_value("prom_data", prom_data, last.exp_data);
		report_value("sprite_data", sprite_data, sprite_expect(last.clatch, last.ca4));
		report_value("fix_pixels", fix_pixels,
			fix_expect(last.slatch, last.sys, last.nsys, last.s2h1));

		errors += uut.u_arbiter.u_checker.fail_count;
		$display("Checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

	// Each entry gets 60 cycles, plus room for reset and the concurrent test
	initial
	begin
		#((n_entries + 8) * 60 * 40);
		$display("Watchdog expired before the tests finished");
		$display("Simulation FAILED");
		$finish;
	end

endmodule

//--- project.f
source/sdram_mux_pkg.sv
source/sdram_arbiter.sv
source/sdram_addr_map.sv
source/sdram_read_capture.sv
source/neogeo_sdram_mux.sv
tb/sdram_model.sv
tb/sdram_mux_checker.sv
tb/tb_neogeo_sdram_mux.sv
